// File: design/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  // ------------------------------
  // widths and constants
  localparam int MANT_W     = 24;
  localparam int GUARD_W    = 3;
  localparam int EXP_BIAS   = 127;
  localparam int MUL_STEPS  = 24;
  // hidden bit position inside the aligned add/sub mantissa
  localparam int HIDDEN_POS = MANT_W + GUARD_W - 1;

  typedef logic [31:0]               float_t;
  typedef logic [7:0]                exp_t;
  typedef logic [MANT_W-1:0]         mant_t;
  // 2 upper guard bits, mantissa, lower guard/round/sticky
  typedef logic [MANT_W+GUARD_W+1:0] ext_mant_t;
  typedef logic [7:0]                byte_t;
  typedef logic [3:0]                reg_addr_t;

  // ------------------------------
  // register map
  localparam reg_addr_t ADDR_A0    = 4'h0;
  localparam reg_addr_t ADDR_A1    = 4'h1;
  localparam reg_addr_t ADDR_A2    = 4'h2;
  localparam reg_addr_t ADDR_A3    = 4'h3;
  localparam reg_addr_t ADDR_B0    = 4'h4;
  localparam reg_addr_t ADDR_B1    = 4'h5;
  localparam reg_addr_t ADDR_B2    = 4'h6;
  localparam reg_addr_t ADDR_B3    = 4'h7;
  localparam reg_addr_t ADDR_OP    = 4'h8;
  // write starts a command, read returns result byte 0
  localparam reg_addr_t ADDR_START = 4'h9;
  localparam reg_addr_t ADDR_R1    = 4'hA;
  localparam reg_addr_t ADDR_R2    = 4'hB;
  localparam reg_addr_t ADDR_R3    = 4'hC;

  localparam float_t RESET_OPERAND = 32'h3F80_0000;

  // ------------------------------
  // enums
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } fpu_op_e;

  typedef enum logic [1:0] {
    main_idle_st, main_wait_st, main_finish_st, main_wait_ack_st
  } main_state_e;

  typedef enum logic [2:0] {
    arith_idle_st, arith_add_sub_st, arith_mul_st, arith_mul_done_st, arith_result_valid_st
  } arith_state_e;

  typedef enum logic [2:0] {
    mul_idle_st, mul_start_st, mul_add_st, mul_shift_st, mul_result_set_st, mul_result_valid_st
  } mul_state_e;

endpackage

`default_nettype wire

// File: design/fpu_regs.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_regs (
  input  logic               clk,
  input  logic               arst,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  fpu_pkg::reg_addr_t addr,
  input  fpu_pkg::byte_t     databus_in,
  input  logic               start_ack,
  input  logic               load_add_sub,
  input  logic               load_mul,
  input  fpu_pkg::float_t    add_sub_result,
  input  fpu_pkg::float_t    mul_result,
  output fpu_pkg::byte_t     databus_out,
  output logic               start_req,
  output fpu_pkg::float_t    operand_a,
  output fpu_pkg::float_t    operand_b,
  output fpu_pkg::fpu_op_e   operation
);

  fpu_pkg::float_t result;
  logic            bus_write;
  logic            bus_read;

  assign bus_write = !cs && !wr;
  assign bus_read  = !cs && !rd;

  // ------------------------------
  // operand and operation registers
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operand_a <= fpu_pkg::RESET_OPERAND;
      operand_b <= fpu_pkg::RESET_OPERAND;
      operation <= fpu_pkg::op_add;
    end else begin
      if (bus_write) begin
        case (addr)
          fpu_pkg::ADDR_A0: operand_a[7:0]   <= databus_in;
          fpu_pkg::ADDR_A1: operand_a[15:8]  <= databus_in;
          fpu_pkg::ADDR_A2: operand_a[23:16] <= databus_in;
          fpu_pkg::ADDR_A3: operand_a[31:24] <= databus_in;
          fpu_pkg::ADDR_B0: operand_b[7:0]   <= databus_in;
          fpu_pkg::ADDR_B1: operand_b[15:8]  <= databus_in;
          fpu_pkg::ADDR_B2: operand_b[23:16] <= databus_in;
          fpu_pkg::ADDR_B3: operand_b[31:24] <= databus_in;
          fpu_pkg::ADDR_OP: operation <= fpu_pkg::fpu_op_e'(databus_in[3:0]);
          default: ;
        endcase
      end
      // accumulator: result also goes back into operand a
      if (load_add_sub) begin
        operand_a <= add_sub_result;
      end else if (load_mul) begin
        operand_a <= mul_result;
      end
    end
  end

  // start request, held until the sequencer acks it
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      start_req <= 1'b0;
    end else if (start_ack) begin
      start_req <= 1'b0;
    end else if (bus_write && addr == fpu_pkg::ADDR_START) begin
      start_req <= 1'b1;
    end
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      result <= '0;
    end else if (load_add_sub) begin
      result <= add_sub_result;
    end else if (load_mul) begin
      result <= mul_result;
    end
  end

  // ------------------------------
  // readback
  always_comb begin
    databus_out = '0;
    if (bus_read) begin
      case (addr)
        fpu_pkg::ADDR_A0:    databus_out = operand_a[7:0];
        fpu_pkg::ADDR_A1:    databus_out = operand_a[15:8];
        fpu_pkg::ADDR_A2:    databus_out = operand_a[23:16];
        fpu_pkg::ADDR_A3:    databus_out = operand_a[31:24];
        fpu_pkg::ADDR_B0:    databus_out = operand_b[7:0];
        fpu_pkg::ADDR_B1:    databus_out = operand_b[15:8];
        fpu_pkg::ADDR_B2:    databus_out = operand_b[23:16];
        fpu_pkg::ADDR_B3:    databus_out = operand_b[31:24];
        fpu_pkg::ADDR_OP:    databus_out = {4'b0000, operation};
        fpu_pkg::ADDR_START: databus_out = result[7:0];
        fpu_pkg::ADDR_R1:    databus_out = result[15:8];
        fpu_pkg::ADDR_R2:    databus_out = result[23:16];
        fpu_pkg::ADDR_R3:    databus_out = result[31:24];
        default:             databus_out = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/fpu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_sequencer (
  input  logic             clk,
  input  logic             arst,
  input  logic             start_req,
  input  fpu_pkg::fpu_op_e operation,
  input  logic             end_ack,
  input  logic             mul_done,
  output logic             start_ack,
  output logic             mul_start,
  output logic             load_add_sub,
  output logic             load_mul,
  output logic             busy,
  output logic             cmd_end
);

  fpu_pkg::main_state_e  main_state;
  fpu_pkg::main_state_e  main_next;
  fpu_pkg::arith_state_e arith_state;
  fpu_pkg::arith_state_e arith_next;

  // ------------------------------
  // main fsm, host command cycle
  always_comb begin
    main_next = main_state;
    case (main_state)
      fpu_pkg::main_idle_st: begin
        if (start_req) main_next = fpu_pkg::main_wait_st;
      end
      fpu_pkg::main_wait_st: begin
        if (arith_state == fpu_pkg::arith_result_valid_st) main_next = fpu_pkg::main_finish_st;
      end
      fpu_pkg::main_finish_st: main_next = fpu_pkg::main_wait_ack_st;
      fpu_pkg::main_wait_ack_st: begin
        if (end_ack) main_next = fpu_pkg::main_idle_st;
      end
      default: main_next = fpu_pkg::main_idle_st;
    endcase
  end

  // ------------------------------
  // arithmetic fsm, dispatch on the operation
  always_comb begin
    arith_next = arith_state;
    case (arith_state)
      fpu_pkg::arith_idle_st: begin
        if (main_state == fpu_pkg::main_wait_st) begin
          case (operation)
            fpu_pkg::op_add, fpu_pkg::op_sub: arith_next = fpu_pkg::arith_add_sub_st;
            fpu_pkg::op_mul:                  arith_next = fpu_pkg::arith_mul_st;
            // unsupported code, finish with no load
            default:                          arith_next = fpu_pkg::arith_result_valid_st;
          endcase
        end
      end
      fpu_pkg::arith_add_sub_st: arith_next = fpu_pkg::arith_result_valid_st;
      fpu_pkg::arith_mul_st: begin
        if (mul_done) arith_next = fpu_pkg::arith_mul_done_st;
      end
      fpu_pkg::arith_mul_done_st: begin
        if (!mul_done) arith_next = fpu_pkg::arith_result_valid_st;
      end
      fpu_pkg::arith_result_valid_st: begin
        if (main_state != fpu_pkg::main_wait_st) arith_next = fpu_pkg::arith_idle_st;
      end
      default: arith_next = fpu_pkg::arith_idle_st;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      main_state   <= fpu_pkg::main_idle_st;
      arith_state  <= fpu_pkg::arith_idle_st;
      start_ack    <= 1'b0;
      mul_start    <= 1'b0;
      load_add_sub <= 1'b0;
      load_mul     <= 1'b0;
      busy         <= 1'b0;
      cmd_end      <= 1'b0;
    end else begin
      main_state   <= main_next;
      arith_state  <= arith_next;
      // any pending request is acked, outside idle it is dropped
      start_ack    <= start_req && !start_ack;
      mul_start    <= (arith_next == fpu_pkg::arith_mul_st);
      load_add_sub <= (arith_state == fpu_pkg::arith_add_sub_st);
      load_mul     <= (arith_state == fpu_pkg::arith_mul_done_st) &&
                      (arith_next == fpu_pkg::arith_result_valid_st);
      busy         <= (main_next != fpu_pkg::main_idle_st);
      cmd_end      <= (main_next == fpu_pkg::main_wait_ack_st);
    end
  end

endmodule

`default_nettype wire

// File: design/fpu_add_sub.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_add_sub (
  input  fpu_pkg::float_t operand_a,
  input  fpu_pkg::float_t operand_b,
  input  logic            subtract,
  output fpu_pkg::float_t result
);

  fpu_pkg::exp_t            a_exp;
  fpu_pkg::exp_t            b_exp;
  fpu_pkg::exp_t            exp_diff;
  logic                     a_larger;
  logic                     b_sign;
  logic                     sum_sign;
  fpu_pkg::ext_mant_t       a_mant;
  fpu_pkg::ext_mant_t       b_mant;
  fpu_pkg::ext_mant_t       a_aligned;
  fpu_pkg::ext_mant_t       b_aligned;
  fpu_pkg::ext_mant_t       sum;
  fpu_pkg::ext_mant_t       mag;
  fpu_pkg::ext_mant_t       norm;
  logic [4:0]               lead_pos;
  logic [9:0]               exp_work;
  logic [9:0]               exp_biased;
  logic                     round_up;
  logic [fpu_pkg::MANT_W:0] mant_rnd;
  logic [22:0]              frac;

  // right shift, bits falling off the end collapse into the sticky bit
  function automatic fpu_pkg::ext_mant_t shift_sticky(input fpu_pkg::ext_mant_t m,
                                                      input fpu_pkg::exp_t sh);
    fpu_pkg::ext_mant_t lost;
    fpu_pkg::ext_mant_t shifted;
    lost       = m & ~(fpu_pkg::ext_mant_t'('1) << sh);
    shifted    = m >> sh;
    shifted[0] = shifted[0] | (|lost);
    return shifted;
  endfunction

  // ------------------------------
  // alignment
  assign a_exp    = operand_a[30:23];
  assign b_exp    = operand_b[30:23];
  assign a_larger = (a_exp >= b_exp);
  assign exp_diff = a_larger ? a_exp - b_exp : b_exp - a_exp;

  assign a_mant = {2'b00, 1'b1, operand_a[22:0], {fpu_pkg::GUARD_W{1'b0}}};
  assign b_mant = {2'b00, 1'b1, operand_b[22:0], {fpu_pkg::GUARD_W{1'b0}}};

  assign a_aligned = a_larger ? a_mant : shift_sticky(a_mant, exp_diff);
  assign b_aligned = a_larger ? shift_sticky(b_mant, exp_diff) : b_mant;

  // ------------------------------
  // signed add, subtract flips the sign of b
  assign b_sign   = operand_b[31] ^ subtract;
  assign sum      = (operand_a[31] ? -a_aligned : a_aligned) + (b_sign ? -b_aligned : b_aligned);
  assign sum_sign = sum[fpu_pkg::HIDDEN_POS + 2];
  assign mag      = sum_sign ? -sum : sum;

  // ------------------------------
  // normalize, round, rebias
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i <= fpu_pkg::HIDDEN_POS; i++) begin
      if (mag[i]) begin
        lead_pos = 5'(i);
      end
    end

    // work on the unbiased exponent of the larger operand
    exp_work = {2'b00, a_larger ? a_exp : b_exp} - 10'(fpu_pkg::EXP_BIAS);
    if (mag[fpu_pkg::HIDDEN_POS + 1]) begin
      // carry out, one step right and keep the sticky
      norm     = mag >> 1;
      norm[0]  = mag[1] | mag[0];
      exp_work = exp_work + 10'd1;
    end else begin
      norm     = mag << (5'(fpu_pkg::HIDDEN_POS) - lead_pos);
      exp_work = exp_work - {5'd0, 5'(fpu_pkg::HIDDEN_POS) - lead_pos};
    end

    // nearest even: guard set and (sticky or odd lsb)
    round_up = norm[fpu_pkg::GUARD_W-1] &
               ((|norm[fpu_pkg::GUARD_W-2:0]) | norm[fpu_pkg::GUARD_W]);
    mant_rnd = {1'b0, norm[fpu_pkg::HIDDEN_POS:fpu_pkg::GUARD_W]} +
               {{fpu_pkg::MANT_W{1'b0}}, round_up};
    if (mant_rnd[fpu_pkg::MANT_W]) begin
      frac     = mant_rnd[fpu_pkg::MANT_W-1:1];
      exp_work = exp_work + 10'd1;
    end else begin
      frac = mant_rnd[fpu_pkg::MANT_W-2:0];
    end

    exp_biased = exp_work + 10'(fpu_pkg::EXP_BIAS);
    // exact cancellation gives +0
    if (mag == '0) begin
      result = '0;
    end else begin
      result = {sum_sign, exp_biased[7:0], frac};
    end
  end

endmodule

`default_nettype wire

// File: design/fpu_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_multiplier (
  input  logic            clk,
  input  logic            arst,
  input  logic            mul_start,
  input  fpu_pkg::float_t operand_a,
  input  fpu_pkg::float_t operand_b,
  output logic            mul_done,
  output fpu_pkg::float_t result
);

  fpu_pkg::mul_state_e        state;
  fpu_pkg::mul_state_e        state_next;
  fpu_pkg::mant_t             multiplicand;
  // upper half accumulates the product, lower half holds the multiplier
  logic [2*fpu_pkg::MANT_W:0] product;
  logic [4:0]                 step_cnt;
  logic [9:0]                 a_exp_unb;
  logic [9:0]                 b_exp_unb;
  logic [9:0]                 exp_sum;
  logic                       prod_top;

  assign prod_top  = product[2*fpu_pkg::MANT_W-1];
  assign a_exp_unb = {2'b00, operand_a[30:23]} - 10'(fpu_pkg::EXP_BIAS);
  assign b_exp_unb = {2'b00, operand_b[30:23]} - 10'(fpu_pkg::EXP_BIAS);
  assign exp_sum   = a_exp_unb + b_exp_unb + 10'(fpu_pkg::EXP_BIAS) + {9'd0, prod_top};

  // ------------------------------
  // multiply fsm
  always_comb begin
    state_next = state;
    case (state)
      fpu_pkg::mul_idle_st: begin
        if (mul_start) state_next = fpu_pkg::mul_start_st;
      end
      fpu_pkg::mul_start_st: state_next = fpu_pkg::mul_add_st;
      fpu_pkg::mul_add_st:   state_next = fpu_pkg::mul_shift_st;
      fpu_pkg::mul_shift_st: begin
        if (step_cnt == 5'(fpu_pkg::MUL_STEPS)) state_next = fpu_pkg::mul_result_set_st;
        else state_next = fpu_pkg::mul_add_st;
      end
      fpu_pkg::mul_result_set_st: state_next = fpu_pkg::mul_result_valid_st;
      fpu_pkg::mul_result_valid_st: begin
        if (!mul_start) state_next = fpu_pkg::mul_idle_st;
      end
      default: state_next = fpu_pkg::mul_idle_st;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state    <= fpu_pkg::mul_idle_st;
      mul_done <= 1'b0;
    end else begin
      state    <= state_next;
      mul_done <= (state_next == fpu_pkg::mul_result_valid_st);
    end
  end

  // ------------------------------
  // shift-and-add datapath
  always_ff @(posedge clk) begin
    case (state)
      fpu_pkg::mul_start_st: begin
        multiplicand <= {1'b1, operand_a[22:0]};
        product      <= {{(fpu_pkg::MANT_W+1){1'b0}}, 1'b1, operand_b[22:0]};
        step_cnt     <= '0;
      end
      fpu_pkg::mul_add_st: begin
        if (product[0]) begin
          product[2*fpu_pkg::MANT_W:fpu_pkg::MANT_W] <=
            product[2*fpu_pkg::MANT_W:fpu_pkg::MANT_W] + {1'b0, multiplicand};
        end
        step_cnt <= step_cnt + 5'd1;
      end
      fpu_pkg::mul_shift_st: product <= product >> 1;
      fpu_pkg::mul_result_set_st: begin
        // one step of normalization, low bits truncated
        result <= {operand_a[31] ^ operand_b[31], exp_sum[7:0],
                   prod_top ? product[2*fpu_pkg::MANT_W-2:fpu_pkg::MANT_W]
                            : product[2*fpu_pkg::MANT_W-3:fpu_pkg::MANT_W-1]};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/fpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_top (
  input  logic               clk,
  input  logic               arst,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  fpu_pkg::reg_addr_t addr,
  input  fpu_pkg::byte_t     databus_in,
  output fpu_pkg::byte_t     databus_out,
  input  logic               end_ack,
  output logic               cmd_end,
  output logic               busy
);

  fpu_pkg::float_t  operand_a;
  fpu_pkg::float_t  operand_b;
  fpu_pkg::float_t  add_sub_result;
  fpu_pkg::float_t  mul_result;
  fpu_pkg::fpu_op_e operation;
  logic             start_req;
  logic             start_ack;
  logic             mul_start;
  logic             mul_done;
  logic             load_add_sub;
  logic             load_mul;

  fpu_regs regs0 (
    .clk(clk), .arst(arst), .cs(cs), .rd(rd), .wr(wr), .addr(addr),
    .databus_in(databus_in), .start_ack(start_ack), .load_add_sub(load_add_sub),
    .load_mul(load_mul), .add_sub_result(add_sub_result), .mul_result(mul_result),
    .databus_out(databus_out), .start_req(start_req), .operand_a(operand_a),
    .operand_b(operand_b), .operation(operation)
  );

  fpu_sequencer seq0 (
    .clk(clk), .arst(arst), .start_req(start_req), .operation(operation),
    .end_ack(end_ack), .mul_done(mul_done), .start_ack(start_ack),
    .mul_start(mul_start), .load_add_sub(load_add_sub), .load_mul(load_mul),
    .busy(busy), .cmd_end(cmd_end)
  );

  // op_sub is the only supported code with bit 0 set
  fpu_add_sub add_sub0 (
    .operand_a(operand_a), .operand_b(operand_b), .subtract(operation[0]),
    .result(add_sub_result)
  );

  fpu_multiplier mul0 (
    .clk(clk), .arst(arst), .mul_start(mul_start), .operand_a(operand_a),
    .operand_b(operand_b), .mul_done(mul_done), .result(mul_result)
  );

endmodule

`default_nettype wire

// File: verification/fpu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_properties (
  input logic clk,
  input logic arst,
  input logic busy,
  input logic cmd_end,
  input logic mul_start,
  input logic mul_done,
  input logic load_add_sub,
  input logic load_mul
);

  int assert_failures = 0;

  // end of command only inside an open command
  cmd_end_busy_a: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else begin
      assert_failures++;
      $error("cmd_end is high while busy is low");
    end

  // four-phase handshake, request drops only once done was seen
  mul_start_fall_a: assert property (@(posedge clk) disable iff (arst)
    $fell(mul_start) |-> $past(mul_done))
    else begin
      assert_failures++;
      $error("mul_start fell before mul_done was high");
    end

  // one source per load
  load_onehot_a: assert property (@(posedge clk) disable iff (arst)
    !(load_add_sub && load_mul))
    else begin
      assert_failures++;
      $error("load_add_sub and load_mul are high together");
    end

endmodule

bind fpu_sequencer fpu_properties props0 (
  .clk(clk), .arst(arst), .busy(busy), .cmd_end(cmd_end), .mul_start(mul_start),
  .mul_done(mul_done), .load_add_sub(load_add_sub), .load_mul(load_mul)
);

`default_nettype wire

// File: verification/fpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_tb;

  localparam int NUM_FIXED      = 12;
  localparam int NUM_RANDOM     = 24;
  localparam int NUM_ROWS       = NUM_FIXED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 120 + 200;

  logic               clk = 1'b0;
  logic               arst;
  logic               cs;
  logic               rd;
  logic               wr;
  fpu_pkg::reg_addr_t addr;
  fpu_pkg::byte_t     databus_in;
  fpu_pkg::byte_t     databus_out;
  logic               end_ack;
  logic               cmd_end;
  logic               busy;

  // stimulus table, a chained row keeps operand a from the last command
  fpu_pkg::float_t tab_a   [NUM_ROWS];
  fpu_pkg::float_t tab_b   [NUM_ROWS];
  logic [3:0]      tab_op  [NUM_ROWS];
  logic            tab_chain [NUM_ROWS];
  fpu_pkg::float_t tab_exp [NUM_ROWS];

  fpu_pkg::float_t cur_a;
  int              mismatches   = 0;
  int              other_errors = 0;
  int              cycle_count  = 0;

  fpu_top dut0 (
    .clk(clk), .arst(arst), .cs(cs), .rd(rd), .wr(wr), .addr(addr),
    .databus_in(databus_in), .databus_out(databus_out), .end_ack(end_ack),
    .cmd_end(cmd_end), .busy(busy)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------
  // reference models

  // exact signed sum in a wide integer, then nearest even to 24 bits
  function automatic fpu_pkg::float_t exact_add_rne(input fpu_pkg::float_t a,
                                                    input fpu_pkg::float_t b,
                                                    input logic sub);
    logic signed [127:0] ma;
    logic signed [127:0] mb;
    logic signed [127:0] sum;
    logic [127:0]        mag;
    logic [127:0]        rest;
    logic [127:0]        half;
    logic [24:0]         keep;
    logic                sign;
    int                  ea;
    int                  eb;
    int                  emin;
    int                  msb;
    int                  sh;
    ea   = a[30:23];
    eb   = b[30:23];
    emin = (ea < eb) ? ea : eb;
    ma   = 128'({1'b1, a[22:0]}) << (ea - emin);
    mb   = 128'({1'b1, b[22:0]}) << (eb - emin);
    if (a[31]) ma = -ma;
    if (b[31] ^ sub) mb = -mb;
    sum = ma + mb;
    if (sum == 0) return '0;
    sign = sum[127];
    mag  = sign ? -sum : sum;
    msb  = 0;
    for (int i = 0; i < 128; i++) begin
      if (mag[i]) msb = i;
    end
    sh = msb - 23;
    if (sh <= 0) begin
      keep = 25'(mag << (-sh));
    end else begin
      keep = 25'(mag >> sh);
      rest = mag & ((128'd1 << sh) - 128'd1);
      half = 128'd1 << (sh - 1);
      if (rest > half || (rest == half && keep[0])) keep = keep + 25'd1;
      if (keep[24]) begin
        keep = keep >> 1;
        sh   = sh + 1;
      end
    end
    return {sign, 8'(emin + sh), keep[22:0]};
  endfunction

  // full mantissa product, one normalization step, low bits dropped
  function automatic fpu_pkg::float_t truncated_mul(input fpu_pkg::float_t a,
                                                    input fpu_pkg::float_t b);
    logic [47:0] p;
    logic [22:0] frac;
    int          e;
    p = {1'b1, a[22:0]} * {1'b1, b[22:0]};
    e = int'(a[30:23]) + int'(b[30:23]) - fpu_pkg::EXP_BIAS;
    if (p[47]) begin
      frac = p[46:24];
      e    = e + 1;
    end else begin
      frac = p[45:23];
    end
    return {a[31] ^ b[31], 8'(e), frac};
  endfunction

  function automatic fpu_pkg::float_t random_normal();
    logic          s;
    fpu_pkg::exp_t e;
    s = $urandom % 2;
    e = fpu_pkg::exp_t'(100 + $urandom % 51);
    return {s, e, 23'($urandom)};
  endfunction

  task automatic set_row(input int r, input fpu_pkg::float_t a, input fpu_pkg::float_t b,
                         input logic [3:0] op, input logic chain, input fpu_pkg::float_t e);
    tab_a[r]     = a;
    tab_b[r]     = b;
    tab_op[r]    = op;
    tab_chain[r] = chain;
    tab_exp[r]   = e;
  endtask

  task automatic fill_table();
    fpu_pkg::float_t a;
    fpu_pkg::float_t b;
    logic [3:0]      op;
    set_row(0, 32'h3FC0_0000, 32'h4010_0000, 4'd0, 1'b0, 32'h4070_0000);
    // 3.75 + 0.25 on the accumulated operand
    set_row(1, 32'h0000_0000, 32'h3E80_0000, 4'd0, 1'b1, 32'h4080_0000);
    set_row(2, 32'h3FC0_0000, 32'h3FC0_0000, 4'd1, 1'b0, 32'h0000_0000);
    // ties, even lsb stays and odd lsb rounds up
    set_row(3, 32'h3F80_0000, 32'h3380_0000, 4'd0, 1'b0, 32'h3F80_0000);
    set_row(4, 32'h3F80_0001, 32'h3380_0000, 4'd0, 1'b0, 32'h3F80_0002);
    set_row(5, 32'hC020_0000, 32'h3F80_0000, 4'd0, 1'b0, 32'hBFC0_0000);
    set_row(6, 32'h3F80_0000, 32'hC040_0000, 4'd1, 1'b0, 32'h4080_0000);
    set_row(7, 32'h3FC0_0000, 32'h4020_0000, 4'd2, 1'b0, 32'h4070_0000);
    set_row(8, 32'h4040_0000, 32'h4040_0000, 4'd2, 1'b0, 32'h4110_0000);
    set_row(9, 32'hC000_0000, 32'h4040_0000, 4'd2, 1'b0, 32'hC0C0_0000);
    // unsupported code keeps the -6.0 result and leaves a at 5.0
    set_row(10, 32'h40A0_0000, 32'h4000_0000, 4'd5, 1'b0, 32'hC0C0_0000);
    set_row(11, 32'h0000_0000, 32'h3F80_0000, 4'd1, 1'b1, 32'h4080_0000);
    for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
      a  = random_normal();
      b  = random_normal();
      op = 4'($urandom % 3);
      set_row(r, a, b, op, 1'b0,
              (op == 4'd2) ? truncated_mul(a, b) : exact_add_rne(a, b, op == 4'd1));
    end
  endtask

  // ------------------------------
  // bus access and checks
  task automatic bus_write(input fpu_pkg::reg_addr_t a, input fpu_pkg::byte_t d);
    cs         = 1'b0;
    wr         = 1'b0;
    addr       = a;
    databus_in = d;
    @(posedge clk);
    #1;
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic bus_read(input fpu_pkg::reg_addr_t a, output fpu_pkg::byte_t d);
    cs   = 1'b0;
    rd   = 1'b0;
    addr = a;
    #2;
    d = databus_out;
    @(posedge clk);
    #1;
    cs = 1'b1;
    rd = 1'b1;
  endtask

  task automatic write_word(input fpu_pkg::reg_addr_t base, input fpu_pkg::float_t w);
    for (int i = 0; i < 4; i++) begin
      bus_write(fpu_pkg::reg_addr_t'(base + i), w[8*i +: 8]);
    end
  endtask

  task automatic read_word(input fpu_pkg::reg_addr_t base, output fpu_pkg::float_t w);
    fpu_pkg::byte_t b;
    for (int i = 0; i < 4; i++) begin
      bus_read(fpu_pkg::reg_addr_t'(base + i), b);
      w[8*i +: 8] = b;
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    other_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic run_row(input int r);
    fpu_pkg::float_t got;
    fpu_pkg::byte_t  op_byte;
    int              ack_delay;
    if (!tab_chain[r]) begin
      write_word(fpu_pkg::ADDR_A0, tab_a[r]);
      cur_a = tab_a[r];
    end
    write_word(fpu_pkg::ADDR_B0, tab_b[r]);
    bus_write(fpu_pkg::ADDR_OP, {4'b0000, tab_op[r]});
    read_word(fpu_pkg::ADDR_A0, got);
    check_word($sformatf("row %0d operand a", r), got, cur_a);
    read_word(fpu_pkg::ADDR_B0, got);
    check_word($sformatf("row %0d operand b", r), got, tab_b[r]);
    bus_read(fpu_pkg::ADDR_OP, op_byte);
    check_word($sformatf("row %0d operation", r), {24'd0, op_byte}, {28'd0, tab_op[r]});
    if (busy) report_error($sformatf("row %0d: busy was high before start", r));
    bus_write(fpu_pkg::ADDR_START, 8'h00);
    // busy follows one edge after the request is stored
    @(posedge clk);
    #1;
    if (!busy) report_error($sformatf("row %0d: busy did not rise after start", r));
    while (!cmd_end) begin
      if (!busy) report_error($sformatf("row %0d: busy dropped before cmd_end", r));
      @(posedge clk);
      #1;
    end
    if (!busy) report_error($sformatf("row %0d: cmd_end came without busy", r));
    ack_delay = $urandom % 8;
    repeat (ack_delay) begin
      @(posedge clk);
      #1;
      if (!cmd_end || !busy) begin
        report_error($sformatf("row %0d: cmd_end or busy dropped before end_ack", r));
      end
    end
    end_ack = 1'b1;
    @(posedge clk);
    #1;
    end_ack = 1'b0;
    if (cmd_end || busy) report_error($sformatf("row %0d: busy or cmd_end stayed high", r));
    read_word(fpu_pkg::ADDR_START, got);
    check_word($sformatf("row %0d result", r), got, tab_exp[r]);
    if (tab_op[r] <= 4'd2) cur_a = tab_exp[r];
    read_word(fpu_pkg::ADDR_A0, got);
    check_word($sformatf("row %0d accumulated operand a", r), got, cur_a);
  endtask

  // ------------------------------
  // main sequence
  initial begin
    int              seed_value;
    fpu_pkg::float_t got;
    arst       = 1'b1;
    cs         = 1'b1;
    rd         = 1'b1;
    wr         = 1'b1;
    addr       = '0;
    databus_in = '0;
    end_ack    = 1'b0;
    seed_value = $urandom(45);
    fill_table();
    repeat (10) @(posedge clk);
    #1;
    arst = 1'b0;

    if (busy || cmd_end) report_error("busy or cmd_end high after reset");
    read_word(fpu_pkg::ADDR_A0, got);
    check_word("reset operand a", got, 32'h3F80_0000);
    read_word(fpu_pkg::ADDR_B0, got);
    check_word("reset operand b", got, 32'h3F80_0000);
    read_word(fpu_pkg::ADDR_START, got);
    check_word("reset result", got, 32'h0000_0000);
    cur_a = 32'h3F80_0000;

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    $display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatches, other_errors, dut0.seq0.props0.assert_failures);
    if (mismatches == 0 && other_errors == 0 && dut0.seq0.props0.assert_failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/fpu_pkg.sv
design/fpu_regs.sv
design/fpu_sequencer.sv
design/fpu_add_sub.sv
design/fpu_multiplier.sv
design/fpu_top.sv
verification/fpu_properties.sv
verification/fpu_tb.sv
